//--- logic/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W   = 11;
    localparam int SCL_HALF = 4;   // CLK cycles per scl half period
    localparam logic [3:0] DEV_CODE = 4'b1010;

    localparam int DIV_W = $clog2(SCL_HALF + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCL_HALF - 1);
    localparam logic [DIV_W-1:0] DIV_MID  = DIV_W'(SCL_HALF / 2);   // sample and update point

    // last half period index of each step
    localparam logic [4:0] PH_FRAME_LAST = 5'd2;   // start and stop
    localparam logic [4:0] PH_BYTE_LAST  = 5'd17;  // nine scl periods

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } eng_op_e;

    typedef struct packed {
        eng_op_e    op;
        logic [7:0] tx;
    } eng_cmd_t;

    typedef struct packed {
        logic [7:0] rx;
        logic       ack_seen;
    } eng_rsp_t;

    // device select byte, 1010 ppp r/w
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] dev_code;
            logic [2:0] page;
            logic       rw;
        } f;
    } ctrl_byte_u;

endpackage

//--- logic/i2c_bit_engine.sv
module i2c_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_go,
    input  eeprom_pkg::eng_cmd_t cmd,
    output logic                 step_done,
    output eeprom_pkg::eng_rsp_t rsp,
    output logic                 scl,
    output logic                 sda_pull,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    logic             active;
    logic             lead;        // one low cycle to put bit 7 on sda
    eng_op_e          op_q;
    logic [4:0]       phase;
    logic [DIV_W-1:0] div_cnt;
    logic [7:0]       tx_sh;
    logic [7:0]       rx_sh;
    logic             ack_q;
    logic [3:0]       bit_idx;
    logic             framing;
    logic [4:0]       last_phase;
    logic             tick_mid;
    logic             tick_end;

    // {scl, sda_pull} per half period of start and stop
    function automatic logic [1:0] frame_lvl(eng_op_e op, logic [4:0] ph);
        case (op)
            OP_START: frame_lvl = (ph == 5'd0) ? 2'b10 : (ph == 5'd1) ? 2'b11 : 2'b01;
            OP_STOP:  frame_lvl = (ph == 5'd0) ? 2'b01 : (ph == 5'd1) ? 2'b11 : 2'b10;
            default:  frame_lvl = {~ph[0], 1'b0};
        endcase
    endfunction

    assign framing    = (op_q == OP_START) || (op_q == OP_STOP);
    assign last_phase = framing ? PH_FRAME_LAST : PH_BYTE_LAST;
    assign bit_idx    = phase[4:1];   // bit 8 is the ack slot
    assign tick_mid   = active && !lead && !framing && (div_cnt == DIV_MID);
    assign tick_end   = active && !lead && (div_cnt == DIV_LAST);

    assign rsp = '{rx: rx_sh, ack_seen: ack_q};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            lead      <= 1'b0;
            op_q      <= OP_STOP;
            phase     <= '0;
            div_cnt   <= '0;
            scl       <= 1'b1;
            sda_pull  <= 1'b0;
            step_done <= 1'b0;
        end
        else
        begin
            step_done <= 1'b0;
            if (!active)
            begin
                if (cmd_go)
                begin
                    active  <= 1'b1;
                    op_q    <= cmd.op;
                    phase   <= '0;
                    div_cnt <= '0;
                    lead    <= (cmd.op == OP_WRITE);
                    if (cmd.op == OP_WRITE)
                        sda_pull <= ~cmd.tx[7];   // scl stays low
                    else
                        {scl, sda_pull} <= frame_lvl(cmd.op, 5'd0);
                end
            end
            else if (lead)
            begin
                lead <= 1'b0;
                scl  <= 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
                if (tick_mid && !scl && op_q == OP_WRITE)
                    sda_pull <= (bit_idx < 4'd7) ? ~tx_sh[6] : 1'b0;   // release for ack
                if (tick_end)
                begin
                    div_cnt <= '0;
                    if (phase == last_phase)
                    begin
                        active    <= 1'b0;
                        step_done <= 1'b1;
                    end
                    else
                    begin
                        phase <= phase + 1'b1;
                        if (framing)
                            {scl, sda_pull} <= frame_lvl(op_q, phase + 5'd1);
                        else
                            scl <= ~scl;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && cmd_go)
            tx_sh <= cmd.tx;
        else if (tick_mid && !scl && bit_idx < 4'd7)
            tx_sh <= tx_sh << 1;
        if (tick_mid && scl)
        begin
            if (bit_idx < 4'd8)
                rx_sh <= {rx_sh[6:0], sda_in};   // msb first
            else
                ack_q <= ~sda_in;
        end
    end

    a_sda_low_scl: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_pull) && !(active && framing) |-> !scl)
        else $error("sda moved while scl high outside start or stop");

    a_idle_scl: assert property (@(posedge CLK) disable iff (RESET)
        !active && op_q == OP_STOP |-> scl)
        else $error("scl low on an idle bus");

endmodule

//--- logic/eeprom_sequencer.sv
module eeprom_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    start,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    busy,
    output logic                    done,
    output logic                    nack,
    output logic [7:0]              rdata,
    output logic                    cmd_go,
    output eeprom_pkg::eng_cmd_t    cmd,
    input  logic                    step_done,
    input  eeprom_pkg::eng_rsp_t    rsp
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP
    } seq_state_e;

    seq_state_e  state;
    seq_state_e  nxt;
    eeprom_req_t req_q;
    logic        acked_step;
    logic        step_open;   // engine step in flight

    function automatic eng_cmd_t step_cmd(seq_state_e s, eeprom_req_t r);
        ctrl_byte_u cb;
        cb.f.dev_code = DEV_CODE;
        cb.f.page     = r.addr[ADDR_W-1:8];
        cb.f.rw       = (s == S_CTRL_R);
        case (s)
            S_START, S_RSTART:  step_cmd = '{op: OP_START, tx: 8'h00};
            S_CTRL_W, S_CTRL_R: step_cmd = '{op: OP_WRITE, tx: cb.raw};
            S_ADDR:             step_cmd = '{op: OP_WRITE, tx: r.addr[7:0]};
            S_DATA:             step_cmd = '{op: OP_WRITE, tx: r.wdata};
            S_READ:             step_cmd = '{op: OP_READ, tx: 8'hff};
            default:            step_cmd = '{op: OP_STOP, tx: 8'h00};
        endcase
    endfunction

    // bytes the slave has to acknowledge
    assign acked_step = (state == S_CTRL_W) || (state == S_ADDR) ||
                        (state == S_DATA) || (state == S_CTRL_R);

    always_comb
    begin
        case (state)
            S_START:  nxt = S_CTRL_W;
            S_CTRL_W: nxt = S_ADDR;
            S_ADDR:   nxt = req_q.write ? S_DATA : S_RSTART;
            S_DATA:   nxt = S_STOP;
            S_RSTART: nxt = S_CTRL_R;
            S_CTRL_R: nxt = S_READ;
            S_READ:   nxt = S_STOP;
            default:  nxt = S_IDLE;
        endcase
        if (acked_step && !rsp.ack_seen)
            nxt = S_STOP;   // abort
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            busy   <= 1'b0;
            done   <= 1'b0;
            nack   <= 1'b0;
            cmd_go <= 1'b0;
        end
        else
        begin
            cmd_go <= 1'b0;
            done   <= 1'b0;
            if (state == S_IDLE)
            begin
                if (start)
                begin
                    busy   <= 1'b1;
                    nack   <= 1'b0;
                    state  <= S_START;
                    cmd_go <= 1'b1;
                end
            end
            else if (step_done)
            begin
                state <= nxt;
                if (acked_step && !rsp.ack_seen)
                    nack <= 1'b1;
                if (nxt == S_IDLE)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                    cmd_go <= 1'b1;   // next step right away
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && start)
        begin
            req_q <= req;
            cmd   <= step_cmd(S_START, req);
        end
        else if (state != S_IDLE && step_done)
            cmd <= step_cmd(nxt, req_q);
        if (state == S_READ && step_done)
            rdata <= rsp.rx;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            step_open <= 1'b0;
        else if (cmd_go)
            step_open <= 1'b1;
        else if (step_done)
            step_open <= 1'b0;
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done held for two cycles");

    a_one_step: assert property (@(posedge CLK) disable iff (RESET)
        cmd_go |-> !step_open)
        else $error("engine command issued while a step is in flight");

endmodule

//--- logic/eeprom_ctrl_top.sv
module eeprom_ctrl_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic                          busy,
    output logic                          done,
    output logic                          nack,
    output logic [7:0]                    rdata,
    output logic                          scl,
    inout  wire                           sda
);
    import eeprom_pkg::*;

    eeprom_req_t req;
    eng_cmd_t    cmd;
    eng_rsp_t    rsp;
    logic        start;
    logic        cmd_go;
    logic        step_done;
    logic        sda_pull;

    assign req   = '{write: wr, addr: addr, wdata: wdata};   // wr wins over rd
    assign start = wr | rd;

    assign sda = sda_pull ? 1'b0 : 1'bz;   // open drain, pull-up on the board

    eeprom_sequencer seq_i (
        .CLK(CLK), .RESET(RESET), .start(start), .req(req),
        .busy(busy), .done(done), .nack(nack), .rdata(rdata),
        .cmd_go(cmd_go), .cmd(cmd), .step_done(step_done), .rsp(rsp)
    );

    i2c_bit_engine eng_i (
        .CLK(CLK), .RESET(RESET), .cmd_go(cmd_go), .cmd(cmd),
        .step_done(step_done), .rsp(rsp),
        .scl(scl), .sda_pull(sda_pull), .sda_in(sda)
    );

endmodule

//--- tests/eeprom_model.sv
module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic ack_disable
);
    import eeprom_pkg::*;

    logic [7:0]        mem [0:(1 << ADDR_W) - 1];
    logic [ADDR_W-1:0] ptr;        // random access pointer
    logic [7:0]        rx_sr;
    logic [7:0]        tx_byte;
    logic [3:0]        bit_cnt;
    int                byte_no;
    logic              active;
    logic              reading;
    logic              want_read;
    logic              ack_ok;
    logic              drive;
    logic              scl_q;
    logic              sda_q;
    ctrl_byte_u        ctrl;

    assign sda = drive ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;   // every address bit shows up
        ptr       = '0;
        rx_sr     = '0;
        tx_byte   = '0;
        bit_cnt   = '0;
        byte_no   = 0;
        active    = 1'b0;
        reading   = 1'b0;
        want_read = 1'b0;
        ack_ok    = 1'b0;
        drive     = 1'b0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
    end

    task automatic take_byte();
        ack_ok = !ack_disable;
        if (byte_no == 0)
        begin
            ctrl.raw        = rx_sr;
            ack_ok          = ack_ok && (ctrl.f.dev_code == DEV_CODE);
            ptr[ADDR_W-1:8] = ctrl.f.page;
            want_read       = ctrl.f.rw;
        end
        else if (byte_no == 1)
            ptr[7:0] = rx_sr;
        else
        begin
            mem[ptr] = rx_sr;
            ptr      = ptr + 1'b1;
        end
    endtask

    task automatic scl_rise();
        if (bit_cnt < 4'd8)
        begin
            rx_sr   = {rx_sr[6:0], sda};
            bit_cnt = bit_cnt + 4'd1;
            if (bit_cnt == 4'd8 && !reading)
                take_byte();
        end
        else
        begin
            bit_cnt = '0;
            byte_no++;
            if (reading ? (sda !== 1'b0) : !ack_ok)
                active = 1'b0;   // no ack on either side ends the transfer
            else if (reading || want_read)
            begin
                reading   = 1'b1;
                want_read = 1'b0;
                tx_byte   = mem[ptr];
                ptr       = ptr + 1'b1;
            end
        end
    endtask

    // sda moving under a high scl is a start or a stop
    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            active    = (sda === 1'b0);
            bit_cnt   = '0;
            byte_no   = 0;
            reading   = 1'b0;
            want_read = 1'b0;
            drive     = 1'b0;
        end
        else if (active && scl === 1'b1 && scl_q === 1'b0)
            scl_rise();
        else if (active && scl === 1'b0 && scl_q === 1'b1)
        begin
            if (bit_cnt == 4'd8)
                drive = !reading && ack_ok;   // ack slot
            else if (reading)
                drive = !tx_byte[3'd7 - bit_cnt[2:0]];
            else
                drive = 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- tests/eeprom_tb.sv
module eeprom_tb;
    import eeprom_pkg::*;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              busy;
    logic              done;
    logic              nack;
    logic [7:0]        rdata;
    logic              scl;
    tri1               sda;
    logic              ack_disable;

    logic [7:0] ref_mem [0:(1 << ADDR_W) - 1];
    int         seed;
    int         cycle_cnt;
    int         phase_len;     // cycles since the last scl edge
    logic       scl_last;
    logic       sda_last;
    logic       sda_moved;     // sda moved in this scl high phase
    logic       strobe_seen;
    logic       exp_read;
    logic       exp_nack;
    logic [7:0] exp_rdata;

    eeprom_ctrl_top dut_i (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .busy(busy), .done(done), .nack(nack), .rdata(rdata), .scl(scl), .sda(sda)
    );

    eeprom_model mem_i (.scl(scl), .sda(sda), .ack_disable(ack_disable));

    always #2 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_last  <= 1'b1;
            sda_last  <= 1'b1;
            phase_len <= 0;
            sda_moved <= 1'b0;
        end
        else
        begin
            scl_last  <= scl;
            sda_last  <= sda;
            phase_len <= (scl != scl_last) ? 1 : phase_len + 1;
            if (scl && !scl_last)
                sda_moved <= 1'b0;
            else if (scl && sda != sda_last)
                sda_moved <= 1'b1;
        end
    end

    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 16 + 20 * 100 * SCL_HALF)   // reset plus about 20 transactions
            abort_run("timeout, the transactions did not all finish in time");
    end

    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !strobe_seen |-> !busy && !done && !nack && scl && sda)
        else abort_run($sformatf("Mismatch idle busy/done/nack/scl/sda: %h %h %h %h %h",
            busy, done, nack, scl, sda));

    a_busy_rise: assert property (@(posedge CLK) disable iff (RESET)
        (wr || rd) && !busy |=> busy)
        else abort_run("busy did not rise after an accepted strobe");

    a_nack: assert property (@(posedge CLK) disable iff (RESET)
        done |-> nack == exp_nack)
        else abort_run($sformatf("Mismatch nack: got %h expected %h", nack, exp_nack));

    a_rdata: assert property (@(posedge CLK) disable iff (RESET)
        done && exp_read |-> rdata == exp_rdata)
        else abort_run($sformatf("Mismatch rdata: got %h expected %h", rdata, exp_rdata));

    a_high_len: assert property (@(posedge CLK) disable iff (RESET)
        $fell(scl) && !sda_moved |-> phase_len == SCL_HALF)
        else abort_run($sformatf("Mismatch scl high cycles: got %h expected %h",
            phase_len, SCL_HALF));

    a_start_hold: assert property (@(posedge CLK) disable iff (RESET)
        $fell(scl) && sda_moved |-> phase_len >= 2 * SCL_HALF && !sda)
        else abort_run("sda changed while scl was high outside a start or stop");

    a_low_len: assert property (@(posedge CLK) disable iff (RESET)
        $rose(scl) |-> phase_len >= SCL_HALF)
        else abort_run($sformatf("Mismatch scl low cycles: got %h expected %h",
            phase_len, SCL_HALF));

    task automatic transfer(input logic is_write, input logic [ADDR_W-1:0] a,
                            input logic [7:0] d, input logic expect_nack);
        @(posedge CLK);
        #1;
        wr          = is_write;
        rd          = !is_write;
        addr        = a;
        wdata       = d;
        exp_read    = !is_write;
        exp_nack    = expect_nack;
        exp_rdata   = ref_mem[a];
        strobe_seen = 1'b1;
        if (is_write && !expect_nack)
            ref_mem[a] = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done();
        do
        begin
            @(posedge CLK);
            #1;
        end
        while (!done);
    endtask

    initial
    begin
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [7:0]        d;
        seed        = 32'he486;
        CLK         = 1'b0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        ack_disable = 1'b0;
        cycle_cnt   = 0;
        strobe_seen = 1'b0;
        exp_read    = 1'b0;
        exp_nack    = 1'b0;
        exp_rdata   = '0;
        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (20) @(posedge CLK);   // quiet bus before the first strobe

        a = ADDR_W'($random(seed));
        d = 8'($random(seed));
        transfer(1'b1, a, d, 1'b0);
        wait_done();
        transfer(1'b0, a, 8'h00, 1'b0);
        wait_done();

        // same low byte, other page bits
        b = a ^ {3'($random(seed)) | 3'b001, 8'h00};
        d = 8'($random(seed));
        transfer(1'b1, a, d, 1'b0);
        wait_done();
        transfer(1'b1, b, ~d, 1'b0);
        wait_done();
        transfer(1'b0, a, 8'h00, 1'b0);
        wait_done();
        transfer(1'b0, b, 8'h00, 1'b0);
        wait_done();

        ack_disable = 1'b1;
        transfer(1'b1, a, d + 8'h33, 1'b1);
        wait_done();
        ack_disable = 1'b0;
        transfer(1'b0, a, 8'h00, 1'b0);
        wait_done();

        // second write strobe lands while busy
        b = ADDR_W'($random(seed));
        d = 8'($random(seed));
        transfer(1'b1, b, d, 1'b0);
        repeat (40) @(posedge CLK);
        #1;
        wr    = 1'b1;
        addr  = b;
        wdata = ~d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        wait_done();
        transfer(1'b0, b, 8'h00, 1'b0);
        wait_done();

        repeat (4)
        begin
            a = ADDR_W'($random(seed));
            d = 8'($random(seed));
            transfer(1'b1, a, d, 1'b0);
            wait_done();
            transfer(1'b0, a, 8'h00, 1'b0);
            wait_done();
        end

        $display("sim passed");
        $finish;
    end

endmodule

//--- flist.f
logic/eeprom_pkg.sv
logic/i2c_bit_engine.sv
logic/eeprom_sequencer.sv
logic/eeprom_ctrl_top.sv
tests/eeprom_model.sv
tests/eeprom_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f flist.f --top-module eeprom_tb \
		-Mdir obj_dir -o eeprom_sim
	./obj_dir/eeprom_sim | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
